//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data word width.
`define XLEN 32

// 64 physical registers.
`define TAG_WIDTH 6

`define IQ_SIZE 8
`define SQN_WIDTH 5

// issue to result ready.
`define DIV_CYCLES (`XLEN + 2)

`endif

//--- rtl/execOpsPkg.sv
`default_nettype none

`include "core_settings.svh"

package execOpsPkg;

    typedef enum logic {
        FU_INT = 1'b0,
        FU_DIV = 1'b1
    } FuType;

    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
    } AluOp;

    typedef enum logic [1:0] {
        DIV, DIVU, REM, REMU
    } DivOp;

    // raw op field, decoded by fu.
    typedef logic [2:0] Op;

    typedef union packed {
        struct packed {
            logic [`XLEN-`TAG_WIDTH-1:0] upper;
            logic [`TAG_WIDTH-1:0] tag;    // source tag when immB is clear.
        } tagView;
        logic [`XLEN-1:0] imm;             // full immediate.
    } OperandB;

endpackage

`default_nettype wire

//--- rtl/coreTypesPkg.sv
`default_nettype none

`include "core_settings.svh"

package coreTypesPkg;
    import execOpsPkg::*;

    typedef logic [`XLEN-1:0] Word;

    // tag 0 is the zero register.
    typedef logic [`TAG_WIDTH-1:0] Tag;

    // compared with wraparound.
    typedef logic [`SQN_WIDTH-1:0] SqN;

    typedef struct packed {
        FuType fu;
        Op op;
        Tag tagDst;
        Tag tagA;
        logic immB;
        OperandB operandB;
    } IssueUOp;

endpackage

`default_nettype wire

//--- rtl/execIf.sv
`timescale 1ns/1ps
`default_nettype none

interface IssueIf
    import coreTypesPkg::*;
();
    logic valid;
    IssueUOp uop;
    SqN sqN;
    Word operandA;
    Word operandB;

    modport queue (output valid, output uop, output sqN);
    modport operands (input uop, output operandA, output operandB);
    modport unit (input valid, input uop, input sqN, input operandA, input operandB);
endinterface

interface WbIf
    import coreTypesPkg::*;
    import execOpsPkg::*;
();
    logic valid;
    Tag tagDst;
    Word result;
    FuType src;    // FU_INT or FU_DIV.

    modport source (output valid, output tagDst, output result, output src);
    modport sink (input valid, input tagDst, input result, input src);
endinterface

`default_nettype wire

//--- rtl/issueQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module issueQueue
    import coreTypesPkg::*;
    import execOpsPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  IssueUOp inUop,
    input  logic divBlock,
    output logic full,
    IssueIf.queue iss,
    WbIf.sink wb
);
    localparam int IDX_W = $clog2(`IQ_SIZE);

    IssueUOp entUop [`IQ_SIZE];
    SqN entSqN [`IQ_SIZE];
    logic [`IQ_SIZE-1:0] entValid;
    logic [`IQ_SIZE-1:0] entRdyA;
    logic [`IQ_SIZE-1:0] entRdyB;
    logic [(1 << `TAG_WIDTH)-1:0] tagReady;
    SqN nextSqN;

    logic enq;
    logic enqRdyA;
    logic enqRdyB;
    logic selFound;
    logic [IDX_W-1:0] freeIdx;
    logic [IDX_W-1:0] selIdx;

    assign full = &entValid;
    assign enq = inValid && !full;

    // a writeback in the enqueue cycle counts as ready.
    assign enqRdyA = tagReady[inUop.tagA] || (wb.valid && wb.tagDst == inUop.tagA);
    assign enqRdyB = inUop.immB || tagReady[inUop.operandB.tagView.tag] ||
                     (wb.valid && wb.tagDst == inUop.operandB.tagView.tag);

    always_comb begin
        freeIdx = '0;
        for (int i = `IQ_SIZE - 1; i >= 0; i--) begin
            if (!entValid[i])
                freeIdx = IDX_W'(i);    // lowest free slot.
        end
    end

    always_comb begin
        selFound = 1'b0;
        selIdx = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (entValid[i] && entRdyA[i] && entRdyB[i] &&
                    !(divBlock && entUop[i].fu == FU_DIV)) begin
                if (!selFound || $signed(SqN'(entSqN[i] - entSqN[selIdx])) < 0) begin
                    selFound = 1'b1;
                    selIdx = IDX_W'(i);
                end
            end
        end
    end

    assign iss.valid = selFound;
    assign iss.uop = entUop[selIdx];
    assign iss.sqN = entSqN[selIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entValid <= '0;
            entRdyA <= '0;
            entRdyB <= '0;
            tagReady <= '1;
            nextSqN <= '0;
        end else begin
            if (wb.valid) begin
                tagReady[wb.tagDst] <= 1'b1;
                for (int i = 0; i < `IQ_SIZE; i++) begin
                    if (entUop[i].tagA == wb.tagDst)
                        entRdyA[i] <= 1'b1;
                    if (entUop[i].operandB.tagView.tag == wb.tagDst)
                        entRdyB[i] <= 1'b1;
                end
            end
            if (selFound)
                entValid[selIdx] <= 1'b0;
            if (enq) begin
                entValid[freeIdx] <= 1'b1;
                entRdyA[freeIdx] <= enqRdyA;
                entRdyB[freeIdx] <= enqRdyB;
                if (inUop.tagDst != '0)
                    tagReady[inUop.tagDst] <= 1'b0;    // pending until written back.
                nextSqN <= nextSqN + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            entUop[freeIdx] <= inUop;
            entSqN[freeIdx] <= nextSqN;
        end
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module regFile
    import coreTypesPkg::*;
(
    input  logic clk,
    input  logic rstN,
    IssueIf.operands iss,
    WbIf.sink wb
);
    Word regs [1 << `TAG_WIDTH];
    logic [(1 << `TAG_WIDTH)-1:0] written;    // unwritten tags read zero.

    function automatic Word readTag(Tag t);
        Word v;
        if (t == '0)
            v = '0;
        else if (wb.valid && wb.tagDst == t)
            v = wb.result;    // same-cycle bypass.
        else if (written[t])
            v = regs[t];
        else
            v = '0;
        return v;
    endfunction

    assign iss.operandA = readTag(iss.uop.tagA);
    assign iss.operandB = iss.uop.immB ? iss.uop.operandB.imm :
                                         readTag(iss.uop.operandB.tagView.tag);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            written <= '0;
        else if (wb.valid && wb.tagDst != '0)
            written[wb.tagDst] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.tagDst != '0)
            regs[wb.tagDst] <= wb.result;
    end

endmodule

`default_nettype wire

//--- rtl/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu
    import coreTypesPkg::*;
    import execOpsPkg::*;
(
    input  logic clk,
    input  logic rstN,
    IssueIf.unit iss,
    output logic resValid,
    output Tag resTag,
    output Word resWord
);
    AluOp aluOp;
    Word a;
    Word b;
    Word res;

    assign aluOp = AluOp'(iss.uop.op);
    assign a = iss.operandA;
    assign b = iss.operandB;

    always_comb begin
        case (aluOp)
            ADD: res = a + b;
            SUB: res = a - b;
            AND: res = a & b;
            OR:  res = a | b;
            XOR: res = a ^ b;
            SLL: res = a << b[4:0];    // shift amount is 5 bits.
            SRL: res = a >> b[4:0];
            SLT: res = Word'($signed(a) < $signed(b));
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            resValid <= 1'b0;
        else
            resValid <= iss.valid && iss.uop.fu == FU_INT;
    end

    always_ff @(posedge clk) begin
        resTag <= iss.uop.tagDst;
        resWord <= res;
    end

endmodule

`default_nettype wire

//--- rtl/divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module divider
    import coreTypesPkg::*;
    import execOpsPkg::*;
(
    input  logic clk,
    input  logic rstN,
    IssueIf.unit iss,
    input  logic taken,
    output logic busy,
    output logic resValid,
    output Tag resTag,
    output Word resWord
);
    localparam int STEPS = `DIV_CYCLES - 2;    // one load and one fixup cycle.
    localparam int STEP_W = $clog2(STEPS + 1);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(STEPS);

    logic start;
    logic signedOp;
    logic running;
    DivOp issOp;
    DivOp curOp;
    Word dividend;
    Word divisor;
    Word quo;
    Word rem;
    Word qFix;
    Word rFix;
    logic negQ;
    logic negR;
    logic divZero;
    logic [STEP_W-1:0] step;
    logic [`XLEN:0] trial;
    logic [`XLEN:0] diff;

    assign issOp = DivOp'(iss.uop.op);
    assign start = iss.valid && iss.uop.fu == FU_DIV;
    assign signedOp = issOp == DIV || issOp == REM;
    assign running = busy && !resValid;

    // quo shifts the dividend out and the quotient in.
    assign trial = {rem, quo[`XLEN-1]};
    assign diff = trial - {1'b0, divisor};

    // min / -1 already comes out as min, remainder 0.
    always_comb begin
        qFix = negQ ? -quo : quo;
        rFix = negR ? -rem : rem;
        if (divZero) begin
            qFix = '1;
            rFix = dividend;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            resValid <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (resValid && taken) begin
            busy <= 1'b0;
            resValid <= 1'b0;
        end else if (running) begin
            if (step != LAST_STEP)
                step <= step + 1'b1;
            else
                resValid <= 1'b1;    // held until written back.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            curOp <= issOp;
            resTag <= iss.uop.tagDst;
            dividend <= iss.operandA;
            quo <= (signedOp && iss.operandA[`XLEN-1]) ? -iss.operandA : iss.operandA;
            divisor <= (signedOp && iss.operandB[`XLEN-1]) ? -iss.operandB : iss.operandB;
            rem <= '0;
            negQ <= signedOp && (iss.operandA[`XLEN-1] ^ iss.operandB[`XLEN-1]);
            negR <= signedOp && iss.operandA[`XLEN-1];
            divZero <= iss.operandB == '0;
        end else if (running) begin
            if (step != LAST_STEP) begin
                rem <= diff[`XLEN] ? trial[`XLEN-1:0] : diff[`XLEN-1:0];
                quo <= {quo[`XLEN-2:0], !diff[`XLEN]};
            end else begin
                resWord <= (curOp == DIV || curOp == DIVU) ? qFix : rFix;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore
    import coreTypesPkg::*;
    import execOpsPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  FuType inFu,
    input  Op inOp,
    input  Tag inTagDst,
    input  Tag inTagA,
    input  logic inImmB,
    input  OperandB inOperandB,
    output logic iqFull,
    output logic wbValid,
    output Tag wbTag,
    output Word wbResult
);
    IssueIf issIf ();
    WbIf wbIf ();

    IssueUOp inUop;
    logic divBlock;
    logic divIssued;
    logic divBusy;
    logic divTaken;
    logic aluValid;
    Tag aluTag;
    Word aluWord;
    logic divValid;
    Tag divTag;
    Word divWord;

    assign inUop = '{fu: inFu, op: inOp, tagDst: inTagDst, tagA: inTagA,
                     immB: inImmB, operandB: inOperandB};

    // no divide issue while busy or right after one issued.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            divIssued <= 1'b0;
        else
            divIssued <= issIf.valid && issIf.uop.fu == FU_DIV;
    end
    assign divBlock = divBusy || divIssued;

    issueQueue iq (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inUop(inUop),
        .divBlock(divBlock), .full(iqFull), .iss(issIf), .wb(wbIf)
    );

    regFile rf (.clk(clk), .rstN(rstN), .iss(issIf), .wb(wbIf));

    intAlu alu (
        .clk(clk), .rstN(rstN), .iss(issIf),
        .resValid(aluValid), .resTag(aluTag), .resWord(aluWord)
    );

    divider div (
        .clk(clk), .rstN(rstN), .iss(issIf), .taken(divTaken), .busy(divBusy),
        .resValid(divValid), .resTag(divTag), .resWord(divWord)
    );

    // alu wins the writeback bus.
    assign wbIf.valid = aluValid || divValid;
    assign wbIf.src = aluValid ? FU_INT : FU_DIV;
    assign wbIf.tagDst = aluValid ? aluTag : divTag;
    assign wbIf.result = aluValid ? aluWord : divWord;
    assign divTaken = wbIf.valid && wbIf.src == FU_DIV;

    assign wbValid = wbIf.valid;
    assign wbTag = wbIf.tagDst;
    assign wbResult = wbIf.result;

endmodule

`default_nettype wire

//--- bench/execCore_checker.sv
`timescale 1ns/1ps
`default_nettype none

module execCore_checker
    import coreTypesPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  logic iqFull,
    input  logic wbValid,
    input  Tag wbTag
);
    int failCount = 0;    // read by the testbench.

    resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> !wbValid && !iqFull)
        else begin
            failCount++;
            $error("wbValid or iqFull high in the first cycle after reset");
        end

    wbKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(wbValid))
        else begin
            failCount++;
            $error("wbValid is unknown out of reset");
        end

    // tag 0 is never a destination.
    wbTagNonZero: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbTag != '0)
        else begin
            failCount++;
            $error("writeback to tag 0");
        end

    noOfferWhenFull: assert property (@(posedge clk) disable iff (!rstN) !(inValid && iqFull))
        else begin
            failCount++;
            $error("micro-op offered while the issue queue is full");
        end

endmodule

`default_nettype wire

//--- bench/execCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execCore_tb
    import coreTypesPkg::*;
    import execOpsPkg::*;
();
    localparam int NUM_TAGS = 1 << $bits(Tag);
    localparam int WAIT_LIMIT = 400;    // one divide takes about 35 cycles.
    localparam int DRAIN_LIMIT = 3000;

    logic clk;
    logic rstN;
    logic inValid;
    FuType inFu;
    Op inOp;
    Tag inTagDst;
    Tag inTagA;
    logic inImmB;
    OperandB inOperandB;
    logic iqFull;
    logic wbValid;
    Tag wbTag;
    Word wbResult;

    Word expVal [NUM_TAGS];
    bit expected [NUM_TAGS];
    Word gotVal [NUM_TAGS];
    int gotCount [NUM_TAGS];
    int gotSeq [NUM_TAGS];
    Tag aheadOf [NUM_TAGS];    // older divide this alu op must beat.
    Tag pendingDiv;
    int seqNum;
    int mismatches;
    int otherErrors;
    bit timedOut;
    bit sawFull;

    execCore UUT (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inFu(inFu), .inOp(inOp),
        .inTagDst(inTagDst), .inTagA(inTagA), .inImmB(inImmB), .inOperandB(inOperandB),
        .iqFull(iqFull), .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult)
    );

    bind execCore execCore_checker chk (
        .clk(clk), .rstN(rstN), .inValid(inValid), .iqFull(iqFull),
        .wbValid(wbValid), .wbTag(wbTag)
    );

    always #2 clk = ~clk;

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            gotVal[wbTag] = wbResult;
            gotCount[wbTag] = gotCount[wbTag] + 1;
            gotSeq[wbTag] = seqNum;
            seqNum = seqNum + 1;
        end
    end

    task automatic checkResult(input Tag tag, input Word got, input Word exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: tag %0d result %h, expected %h", $time, tag, got, exp);
        end
    endtask

    task automatic checkCount(input Tag tag, input int count);
        int want;
        want = expected[tag] ? 1 : 0;
        if (count != want) begin
            otherErrors++;
            $display("tag %0d was written back %0d times instead of %0d", tag, count, want);
        end
    endtask

    task automatic checkOrder(input Tag aluTag, input Tag divTag);
        if (gotCount[aluTag] > 0 && gotCount[divTag] > 0 && gotSeq[aluTag] > gotSeq[divTag]) begin
            otherErrors++;
            $display("tag %0d wrote back after the older divide on tag %0d", aluTag, divTag);
        end
    endtask

    task automatic waitForSlot();
        int cycles;
        cycles = 0;
        while (iqFull && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (iqFull) begin
            timedOut = 1'b1;
            otherErrors++;
            $display("timed out waiting for a free issue queue entry");
        end
    endtask

    task automatic offerUop(input logic [31:0] fuV, input logic [31:0] opV,
                            input logic [31:0] dstV, input logic [31:0] aV,
                            input logic [31:0] immV, input logic [31:0] bV);
        FuType fu;
        Tag tagB;
        bit srcDone;
        fu = FuType'(fuV[0]);
        tagB = Tag'(bV);
        srcDone = (Tag'(aV) == '0 || gotCount[Tag'(aV)] > 0) &&
                  (immV[0] || tagB == '0 || gotCount[tagB] > 0);
        if (fu == FU_DIV)
            pendingDiv = Tag'(dstV);
        else if (srcDone && pendingDiv != '0 && gotCount[pendingDiv] == 0)
            aheadOf[Tag'(dstV)] = pendingDiv;    // one-cycle alu beats the divider.
        inFu = fu;
        inOp = Op'(opV[2:0]);
        inTagDst = Tag'(dstV);
        inTagA = Tag'(aV);
        inImmB = immV[0];
        inOperandB = bV;
        inValid = 1'b1;
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    initial begin
        int fd;
        int n;
        int gap;
        int cycles;
        int unsigned seed;
        bit allDone;
        string line;
        logic [31:0] fuV, opV, dstV, aV, immV, bV, expV;
        seed = $urandom(73047);
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        inFu = FU_INT;
        inOp = '0;
        inTagDst = '0;
        inTagA = '0;
        inImmB = 1'b0;
        inOperandB = '0;
        pendingDiv = '0;
        seqNum = 0;
        mismatches = 0;
        otherErrors = 0;
        timedOut = 1'b0;
        sawFull = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            expected[t] = 1'b0;
            expVal[t] = '0;
            gotVal[t] = '0;
            gotCount[t] = 0;
            gotSeq[t] = 0;
            aheadOf[t] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);
        #1;

        fd = $fopen("bench/exec_tests.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("cannot open bench/exec_tests.txt");
        end else begin
            while (!$feof(fd) && !timedOut) begin
                line = "";
                if ($fgets(line, fd) != 0)
                    n = $sscanf(line, "%h %h %h %h %h %h %h", fuV, opV, dstV, aV, immV, bV, expV);
                else
                    n = 0;
                if (n == 7) begin    // comment lines parse to nothing.
                    expected[Tag'(dstV)] = 1'b1;
                    expVal[Tag'(dstV)] = expV;
                    waitForSlot();
                    if (!timedOut) begin
                        offerUop(fuV, opV, dstV, aV, immV, bV);
                        gap = int'($urandom % 4);
                        repeat (gap) begin
                            @(posedge clk);
                            #1;
                        end
                    end
                end
            end
            sawFull = iqFull;    // the last eight wait on a pending divide.
            $fclose(fd);
        end

        cycles = 0;
        allDone = 1'b0;
        while (!timedOut && !allDone) begin
            allDone = 1'b1;
            for (int t = 1; t < NUM_TAGS; t++) begin
                if (expected[t] && gotCount[t] == 0)
                    allDone = 1'b0;
            end
            if (!allDone) begin
                if (cycles == DRAIN_LIMIT) begin
                    timedOut = 1'b1;
                    otherErrors++;
                    $display("timed out waiting for the remaining writebacks");
                end else begin
                    @(posedge clk);
                    cycles++;
                end
            end
        end
        repeat (40) @(posedge clk);    // catch late duplicates.
        #1;

        for (int t = 0; t < NUM_TAGS; t++) begin
            checkCount(Tag'(t), gotCount[t]);
            if (expected[t] && gotCount[t] > 0)
                checkResult(Tag'(t), gotVal[t], expVal[t]);
            if (aheadOf[t] != '0)
                checkOrder(Tag'(t), aheadOf[t]);
        end
        if (!sawFull) begin
            otherErrors++;
            $display("the issue queue was not full with the last micro-ops waiting on a divide");
        end
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, otherErrors, UUT.chk.failCount);
        if (mismatches + otherErrors + UUT.chk.failCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/exec_tests.txt
# columns in hex: fu op tagDst tagA immB operandB expected
# fu 0 alu, 1 div; alu op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt; div op 0 div 1 divu 2 rem 3 remu
# constants
0 0 01 00 1 12345678 12345678
0 0 02 00 1 fffffff0 fffffff0
0 0 03 00 1 80000000 80000000
# alu operations with immediate operand b
0 0 04 01 1 11111111 23456789
0 1 05 01 1 00000678 12345000
0 2 06 01 1 0f0f0f0f 02040608
0 3 07 01 1 f0000001 f2345679
0 4 08 01 1 ffffffff edcba987
0 5 09 01 1 00000024 23456780
0 6 0a 02 1 00000104 0fffffff
0 7 0b 02 1 00000001 00000001
0 7 0c 01 1 fffffff0 00000000
# dependent chain
0 0 0d 01 0 00000001 2468acf0
0 1 0e 0d 0 00000001 12345678
0 4 0f 0e 0 00000002 edcba988
0 6 10 0f 1 00000008 00edcba9
# divide and remainder
1 0 11 01 1 00000007 0299c335
1 2 12 01 1 00000007 00000005
1 0 13 02 1 00000003 fffffffb
1 2 14 02 1 00000003 ffffffff
1 1 15 02 1 00000003 55555550
1 3 16 02 1 00000007 00000002
1 0 17 01 1 00000000 ffffffff
1 2 18 01 1 00000000 12345678
1 0 19 03 1 ffffffff 80000000
1 2 1a 03 1 ffffffff 00000000
# independent alu op after a divide
1 0 1b 01 1 00000003 06117228
0 3 1c 02 1 00000005 fffffff5
# eight consumers of a pending divide
1 1 1d 01 1 00000010 01234567
0 0 1e 1d 1 00000001 01234568
0 0 1f 1d 1 00000002 01234569
0 0 20 1d 1 00000003 0123456a
0 0 21 1d 1 00000004 0123456b
0 0 22 1d 1 00000005 0123456c
0 0 23 1d 1 00000006 0123456d
0 0 24 1d 1 00000007 0123456e
0 0 25 1d 1 00000008 0123456f

//--- files.f
+incdir+include
rtl/execOpsPkg.sv
rtl/coreTypesPkg.sv
rtl/execIf.sv
rtl/issueQueue.sv
rtl/regFile.sv
rtl/intAlu.sv
rtl/divider.sv
rtl/execCore.sv
bench/execCore_checker.sv
bench/execCore_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module execCore_tb -Mdir obj_dir
out=$(./obj_dir/VexecCore_tb +verilator+error+limit+100 || true)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"
